/* src/decoder_pkg.sv */
package decoder_pkg;

    // Global stage driven by the environment
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3
    } stage_e;

    localparam int DEFAULT_GRID_WIDTH_X = 4;  // Units per round
    localparam int DEFAULT_GRID_WIDTH_U = 3;  // Measurement rounds
    localparam int DEFAULT_MAX_WEIGHT   = 2;  // Uniform edge weight

    // Bits needed for a unit address, round * X + column
    function automatic int root_width(input int grid_x, input int grid_u);
        int width;
        width = $clog2(grid_x * grid_u);
        if (width < 1) begin
            width = 1;
        end
        return width;
    endfunction

    // Bits needed to count growth up to the full weight
    function automatic int growth_width(input int max_weight);
        int width;
        width = $clog2(max_weight + 1);
        if (width < 1) begin
            width = 1;
        end
        return width;
    endfunction

endpackage

/* src/unit_link_if.sv */
`timescale 1ns/1ns

interface unit_link_if #(
    parameter int ROOT_WIDTH = decoder_pkg::root_width(decoder_pkg::DEFAULT_GRID_WIDTH_X,
                                                       decoder_pkg::DEFAULT_GRID_WIDTH_U)
);
    logic [ROOT_WIDTH-1:0] root;           // Current cluster label of the unit
    logic                  has_defect;
    logic                  at_boundary;
    logic                  active;         // Defect present, no boundary reached
    logic [ROOT_WIDTH-1:0] peer_root;      // All ones means no peer
    logic                  peer_defect;
    logic                  peer_boundary;

    modport unit (
        output root,
        output has_defect,
        output at_boundary,
        output active,
        input  peer_root,
        input  peer_defect,
        input  peer_boundary
    );

    modport link (
        input  root,
        input  has_defect,
        input  at_boundary,
        input  active,
        output peer_root,
        output peer_defect,
        output peer_boundary
    );

endinterface

/* src/growth_link.sv */
`timescale 1ns/1ns

module growth_link #(
    parameter int ROOT_WIDTH  = 4,
    parameter int MAX_WEIGHT  = 2,
    parameter bit IS_BOUNDARY = 1'b0
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  decoder_pkg::stage_e global_stage_i,
    unit_link_if.link           side_a,
    unit_link_if.link           side_b,
    output logic                fully_grown_o
);
    import decoder_pkg::*;

    localparam int GW = growth_width(MAX_WEIGHT);

    logic [GW-1:0] growth_q;
    logic [1:0]    increase;     // Active endpoints this cycle
    logic [GW+1:0] growth_sum;   // Room for two increments
    logic          grown;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            growth_q <= '0;
        end else if (global_stage_i == STAGE_MEASUREMENT_LOADING) begin
            growth_q <= '0;
        end else if (global_stage_i == STAGE_GROW) begin
            if (growth_sum >= MAX_WEIGHT) begin
                growth_q <= GW'(MAX_WEIGHT);  // Saturate
            end else begin
                growth_q <= GW'(growth_sum);
            end
        end
    end

    assign growth_sum    = {2'b00, growth_q} + {{GW{1'b0}}, increase};
    assign grown         = (growth_q == GW'(MAX_WEIGHT));
    assign fully_grown_o = grown;

    if (IS_BOUNDARY) begin : g_boundary
        // The boundary acts as a peer that only brings its boundary flag
        assign increase             = {1'b0, side_a.active};
        assign side_a.peer_root     = {ROOT_WIDTH{1'b1}};
        assign side_a.peer_defect   = 1'b0;
        assign side_a.peer_boundary = grown;
    end else begin : g_internal
        assign increase = {1'b0, side_a.active} + {1'b0, side_b.active};

        // Cluster data crosses only a fully grown edge
        assign side_a.peer_root     = grown ? side_b.root : {ROOT_WIDTH{1'b1}};
        assign side_a.peer_defect   = grown & side_b.has_defect;
        assign side_a.peer_boundary = grown & side_b.at_boundary;

        assign side_b.peer_root     = grown ? side_a.root : {ROOT_WIDTH{1'b1}};
        assign side_b.peer_defect   = grown & side_a.has_defect;
        assign side_b.peer_boundary = grown & side_a.at_boundary;
    end

endmodule

/* src/processing_unit.sv */
`timescale 1ns/1ns

module processing_unit #(
    parameter int ROOT_WIDTH = 4,
    parameter int ADDRESS    = 0
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  decoder_pkg::stage_e   global_stage_i,
    input  logic                  measurement_i,
    output logic                  measurement_o,
    unit_link_if.unit             west,
    unit_link_if.unit             east,
    unit_link_if.unit             down,
    unit_link_if.unit             up,
    output logic [ROOT_WIDTH-1:0] root_o,
    output logic                  active_o,
    output logic                  busy_o
);
    import decoder_pkg::*;

    localparam logic [ROOT_WIDTH-1:0] OWN_ADDRESS = ROOT_WIDTH'(ADDRESS);

    logic                  syndrome_q;     // Shift register stage of the syndrome
    logic [ROOT_WIDTH-1:0] root_q;
    logic                  defect_q;
    logic                  boundary_q;
    logic                  busy_q;
    logic [ROOT_WIDTH-1:0] min_we;
    logic [ROOT_WIDTH-1:0] min_du;
    logic [ROOT_WIDTH-1:0] min_peer;
    logic [ROOT_WIDTH-1:0] root_next;
    logic                  defect_next;
    logic                  boundary_next;
    logic                  active;

    // Smallest label seen over grown edges, absent peers read all ones
    always_comb begin
        min_we    = (west.peer_root < east.peer_root) ? west.peer_root : east.peer_root;
        min_du    = (down.peer_root < up.peer_root) ? down.peer_root : up.peer_root;
        min_peer  = (min_we < min_du) ? min_we : min_du;
        root_next = (root_q < min_peer) ? root_q : min_peer;
    end

    assign defect_next   = defect_q | west.peer_defect | east.peer_defect
                         | down.peer_defect | up.peer_defect;
    assign boundary_next = boundary_q | west.peer_boundary | east.peer_boundary
                         | down.peer_boundary | up.peer_boundary;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            syndrome_q <= 1'b0;
            root_q     <= OWN_ADDRESS;
            defect_q   <= 1'b0;
            boundary_q <= 1'b0;
            busy_q     <= 1'b0;
        end else begin
            case (global_stage_i)
                STAGE_MEASUREMENT_LOADING: begin
                    syndrome_q <= measurement_i;  // Take the round above
                    root_q     <= OWN_ADDRESS;
                    defect_q   <= measurement_i;
                    boundary_q <= 1'b0;
                    busy_q     <= 1'b0;
                end
                STAGE_MERGE: begin
                    root_q     <= root_next;
                    defect_q   <= defect_next;
                    boundary_q <= boundary_next;
                    busy_q     <= (root_next != root_q) || (defect_next != defect_q)
                               || (boundary_next != boundary_q);
                end
                default: begin
                    busy_q <= 1'b0;  // Idle and grow keep the cluster data
                end
            endcase
        end
    end

    assign active        = defect_q & ~boundary_q;
    assign measurement_o = syndrome_q;
    assign root_o        = root_q;
    assign active_o      = active;
    assign busy_o        = busy_q;

    // Same view of the cluster on every side
    assign west.root        = root_q;
    assign west.has_defect  = defect_q;
    assign west.at_boundary = boundary_q;
    assign west.active      = active;
    assign east.root        = root_q;
    assign east.has_defect  = defect_q;
    assign east.at_boundary = boundary_q;
    assign east.active      = active;
    assign down.root        = root_q;
    assign down.has_defect  = defect_q;
    assign down.at_boundary = boundary_q;
    assign down.active      = active;
    assign up.root          = root_q;
    assign up.has_defect    = defect_q;
    assign up.at_boundary   = boundary_q;
    assign up.active        = active;

endmodule

/* src/decoding_graph.sv */
`timescale 1ns/1ns

module decoding_graph #(
    parameter int GRID_WIDTH_X = decoder_pkg::DEFAULT_GRID_WIDTH_X,
    parameter int GRID_WIDTH_U = decoder_pkg::DEFAULT_GRID_WIDTH_U,
    parameter int MAX_WEIGHT   = decoder_pkg::DEFAULT_MAX_WEIGHT
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  decoder_pkg::stage_e                   global_stage_i,
    input  logic [GRID_WIDTH_X-1:0]               measurements_i,
    output logic [GRID_WIDTH_X*GRID_WIDTH_U-1:0]  active_o,
    output logic [GRID_WIDTH_X*GRID_WIDTH_U
                  *decoder_pkg::root_width(GRID_WIDTH_X, GRID_WIDTH_U)-1:0] roots_o,
    output logic [GRID_WIDTH_X*GRID_WIDTH_U-1:0]  busy_o,
    output logic [GRID_WIDTH_X:0]                 correction_o
);
    import decoder_pkg::*;

    localparam int RW       = root_width(GRID_WIDTH_X, GRID_WIDTH_U);
    localparam int PU_COUNT = GRID_WIDTH_X * GRID_WIDTH_U;
    localparam int TOP      = (GRID_WIDTH_U - 1) * GRID_WIDTH_X;  // First address of top round

    // One interface per unit side, indexed by unit address
    unit_link_if #(.ROOT_WIDTH(RW)) west_if [PU_COUNT] ();
    unit_link_if #(.ROOT_WIDTH(RW)) east_if [PU_COUNT] ();
    unit_link_if #(.ROOT_WIDTH(RW)) down_if [PU_COUNT] ();
    unit_link_if #(.ROOT_WIDTH(RW)) up_if   [PU_COUNT] ();

    logic [PU_COUNT-1:0]   measurement_out;       // Syndrome handed to the round below
    logic [GRID_WIDTH_X:0] h_grown [GRID_WIDTH_U];

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : g_round
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : g_unit
            localparam int ADDR = k * GRID_WIDTH_X + i;
            logic measurement_in;

            if (k == GRID_WIDTH_U - 1) begin : g_top
                assign measurement_in = measurements_i[i];
            end else begin : g_below
                assign measurement_in = measurement_out[ADDR + GRID_WIDTH_X];
            end

            processing_unit #(
                .ROOT_WIDTH(RW),
                .ADDRESS   (ADDR)
            ) pu (
                .clk_i         (clk_i),
                .rst_n_i       (rst_n_i),
                .global_stage_i(global_stage_i),
                .measurement_i (measurement_in),
                .measurement_o (measurement_out[ADDR]),
                .west          (west_if[ADDR]),
                .east          (east_if[ADDR]),
                .down          (down_if[ADDR]),
                .up            (up_if[ADDR]),
                .root_o        (roots_o[ADDR*RW +: RW]),
                .active_o      (active_o[ADDR]),
                .busy_o        (busy_o[ADDR])
            );
        end

        // Horizontal links, both ends are boundaries
        for (genvar j = 0; j <= GRID_WIDTH_X; j++) begin : g_h_link
            if (j == 0) begin : g_west_edge
                growth_link #(.ROOT_WIDTH(RW), .MAX_WEIGHT(MAX_WEIGHT), .IS_BOUNDARY(1'b1)) link (
                    .clk_i(clk_i), .rst_n_i(rst_n_i), .global_stage_i(global_stage_i),
                    .side_a       (west_if[k*GRID_WIDTH_X]),
                    .side_b       (west_if[k*GRID_WIDTH_X]),  // No far side
                    .fully_grown_o(h_grown[k][j])
                );
            end else if (j == GRID_WIDTH_X) begin : g_east_edge
                growth_link #(.ROOT_WIDTH(RW), .MAX_WEIGHT(MAX_WEIGHT), .IS_BOUNDARY(1'b1)) link (
                    .clk_i(clk_i), .rst_n_i(rst_n_i), .global_stage_i(global_stage_i),
                    .side_a       (east_if[k*GRID_WIDTH_X + j - 1]),
                    .side_b       (east_if[k*GRID_WIDTH_X + j - 1]),
                    .fully_grown_o(h_grown[k][j])
                );
            end else begin : g_inner
                growth_link #(.ROOT_WIDTH(RW), .MAX_WEIGHT(MAX_WEIGHT), .IS_BOUNDARY(1'b0)) link (
                    .clk_i(clk_i), .rst_n_i(rst_n_i), .global_stage_i(global_stage_i),
                    .side_a       (east_if[k*GRID_WIDTH_X + j - 1]),
                    .side_b       (west_if[k*GRID_WIDTH_X + j]),
                    .fully_grown_o(h_grown[k][j])
                );
            end
        end
    end

    // Vertical links between adjacent rounds
    for (genvar k = 0; k < GRID_WIDTH_U - 1; k++) begin : g_v_round
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : g_v_link
            growth_link #(.ROOT_WIDTH(RW), .MAX_WEIGHT(MAX_WEIGHT), .IS_BOUNDARY(1'b0)) link (
                .clk_i(clk_i), .rst_n_i(rst_n_i), .global_stage_i(global_stage_i),
                .side_a       (up_if[k*GRID_WIDTH_X + i]),
                .side_b       (down_if[(k+1)*GRID_WIDTH_X + i]),
                .fully_grown_o()
            );
        end
    end

    // Nothing below round 0 or above the top round
    for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : g_time_edge
        assign down_if[i].peer_root          = {RW{1'b1}};
        assign down_if[i].peer_defect        = 1'b0;
        assign down_if[i].peer_boundary      = 1'b0;
        assign up_if[TOP + i].peer_root      = {RW{1'b1}};
        assign up_if[TOP + i].peer_defect    = 1'b0;
        assign up_if[TOP + i].peer_boundary  = 1'b0;
    end

    assign correction_o = h_grown[0];  // Round 0 edges, west to east

endmodule

/* test/decoding_graph_checker.sv */
`timescale 1ns/1ns

module decoding_graph_checker #(
    parameter int GRID_WIDTH_X = decoder_pkg::DEFAULT_GRID_WIDTH_X,
    parameter int GRID_WIDTH_U = decoder_pkg::DEFAULT_GRID_WIDTH_U,
    parameter int RW           = decoder_pkg::root_width(GRID_WIDTH_X, GRID_WIDTH_U)
) (
    input logic                                     clk_i,
    input logic                                     rst_n_i,
    input decoder_pkg::stage_e                      global_stage_i,
    input logic [GRID_WIDTH_X*GRID_WIDTH_U-1:0]     busy_i,
    input logic [GRID_WIDTH_X*GRID_WIDTH_U*RW-1:0]  roots_i
);
    import decoder_pkg::*;

    localparam int N = GRID_WIDTH_X * GRID_WIDTH_U;

    int assert_failures = 0;  // Read by the testbench at the end of the run

    // Every unit labelled with its own address
    function automatic logic [N*RW-1:0] own_roots();
        logic [N*RW-1:0] v;
        for (int a = 0; a < N; a++) begin
            v[a*RW +: RW] = RW'(a);
        end
        return v;
    endfunction

    a_busy_reset: assert property (@(posedge clk_i) !rst_n_i |=> busy_i == '0)
        else begin
            assert_failures++;
            $error("busy_o not clear in the cycle after reset");
        end

    a_roots_reset: assert property (@(posedge clk_i) !rst_n_i |=> roots_i == own_roots())
        else begin
            assert_failures++;
            $error("roots_o not at own addresses in the cycle after reset");
        end

    a_grow_not_busy: assert property (@(posedge clk_i)
            (rst_n_i && global_stage_i == STAGE_GROW) |=> busy_i == '0)
        else begin
            assert_failures++;
            $error("busy_o raised by a grow cycle");
        end

    a_idle_holds: assert property (@(posedge clk_i)
            (rst_n_i && global_stage_i == STAGE_IDLE) |=> $stable(roots_i))
        else begin
            assert_failures++;
            $error("roots_o changed during an idle cycle");
        end

endmodule

bind decoding_graph decoding_graph_checker #(
    .GRID_WIDTH_X(GRID_WIDTH_X),
    .GRID_WIDTH_U(GRID_WIDTH_U)
) stage_checks (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .global_stage_i(global_stage_i),
    .busy_i        (busy_o),
    .roots_i       (roots_o)
);

/* test/decoding_graph_tb.sv */
`timescale 1ns/1ns

module decoding_graph_tb;
    import decoder_pkg::*;

    localparam int X           = DEFAULT_GRID_WIDTH_X;
    localparam int U           = DEFAULT_GRID_WIDTH_U;
    localparam int W           = DEFAULT_MAX_WEIGHT;
    localparam int N           = X * U;
    localparam int RW          = root_width(X, U);
    localparam int ROWS        = 5;
    localparam int MAX_ITERS   = 2;  // Largest iteration count in the table
    localparam int CYCLE_LIMIT = ROWS * (U + MAX_ITERS * 20) + 200;

    typedef struct packed {
        logic [U-1:0][X-1:0] meas;           // Index k lands in round k
        logic [3:0]          iters;
        logic                random_syndrome;
        logic [N-1:0]        exp_active;
        logic [X:0]          exp_correction;
    } row_t;

    localparam row_t SCENARIOS [ROWS] = '{
        '{12'h492, 4'd0, 1'b0, 12'h492, 5'h00},  // Loading only
        '{12'h006, 4'd1, 1'b0, 12'h006, 5'h04},  // Horizontal pair in round 0
        '{12'h001, 4'd2, 1'b0, 12'h000, 5'h03},  // Reaches the west boundary
        '{12'h044, 4'd1, 1'b0, 12'h044, 5'h00},  // Vertical pair
        '{12'h000, 4'd2, 1'b1, 12'h000, 5'h00}   // Random syndromes
    };

    logic                  clk = 1'b0;
    logic                  rst_n;
    stage_e                stage;
    logic [X-1:0]          measurements;
    logic [N-1:0]          active_o;
    logic [N*RW-1:0]       roots_o;
    logic [N-1:0]          busy_o;
    logic [X:0]            correction_o;

    int           errors = 0;
    int           cycles = 0;
    logic [N-1:0] syn;            // Reference model state
    int           lbl [N];
    int           hcnt [U][X+1];
    int           vcnt [U-1][X];
    logic [N-1:0] m_active;
    logic [X:0]   m_correction;

    decoding_graph #(.GRID_WIDTH_X(X), .GRID_WIDTH_U(U), .MAX_WEIGHT(W)) dut0 (
        .clk_i(clk), .rst_n_i(rst_n), .global_stage_i(stage), .measurements_i(measurements),
        .active_o(active_o), .roots_o(roots_o), .busy_o(busy_o), .correction_o(correction_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Both units take the smaller label, reports whether anything moved
    function automatic bit join_units(input int a, input int b);
        int low;
        low = (lbl[a] < lbl[b]) ? lbl[a] : lbl[b];
        join_units = (lbl[a] != low) || (lbl[b] != low);
        lbl[a] = low;
        lbl[b] = low;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected == actual) else begin
            errors++;
            $display("MISMATCH %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    // Components over fully grown edges, min address and OR of flags per component
    task automatic settle_model();
        bit           changed;
        logic [N-1:0] comp_defect;
        logic [N-1:0] comp_boundary;
        for (int a = 0; a < N; a++) lbl[a] = a;
        do begin
            changed = 1'b0;
            for (int k = 0; k < U; k++)
                for (int j = 1; j < X; j++)
                    if (hcnt[k][j] == W) changed = changed | join_units(k*X + j - 1, k*X + j);
            for (int k = 0; k < U - 1; k++)
                for (int i = 0; i < X; i++)
                    if (vcnt[k][i] == W) changed = changed | join_units(k*X + i, (k+1)*X + i);
        end while (changed);
        comp_defect   = '0;
        comp_boundary = '0;
        for (int a = 0; a < N; a++) if (syn[a]) comp_defect[lbl[a]] = 1'b1;
        for (int k = 0; k < U; k++) begin
            if (hcnt[k][0] == W) comp_boundary[lbl[k*X]] = 1'b1;
            if (hcnt[k][X] == W) comp_boundary[lbl[k*X + X - 1]] = 1'b1;
        end
        for (int a = 0; a < N; a++) m_active[a] = comp_defect[lbl[a]] & ~comp_boundary[lbl[a]];
        for (int j = 0; j <= X; j++) m_correction[j] = (hcnt[0][j] == W);
    endtask

    task automatic grow_model();
        int inc;
        for (int k = 0; k < U; k++) begin
            for (int j = 0; j <= X; j++) begin
                if (j == 0) inc = int'(m_active[k*X]);
                else if (j == X) inc = int'(m_active[k*X + X - 1]);
                else inc = int'(m_active[k*X + j - 1]) + int'(m_active[k*X + j]);
                hcnt[k][j] = (hcnt[k][j] + inc > W) ? W : hcnt[k][j] + inc;
            end
        end
        for (int k = 0; k < U - 1; k++) begin
            for (int i = 0; i < X; i++) begin
                inc = int'(m_active[k*X + i]) + int'(m_active[(k+1)*X + i]);
                vcnt[k][i] = (vcnt[k][i] + inc > W) ? W : vcnt[k][i] + inc;
            end
        end
    endtask

    task automatic load_model(input logic [U-1:0][X-1:0] meas);
        syn = meas;
        foreach (hcnt[k, j]) hcnt[k][j] = 0;
        foreach (vcnt[k, i]) vcnt[k][i] = 0;
        settle_model();
    endtask

    task automatic check_against_model();
        for (int a = 0; a < N; a++)
            check_value($sformatf("roots_o[%0d]", a), 64'(lbl[a]), 64'(roots_o[a*RW +: RW]));
        check_value("active_o", 64'(m_active), 64'(active_o));
        check_value("correction_o", 64'(m_correction), 64'(correction_o));
        check_value("busy_o", 64'(0), 64'(busy_o));
    endtask

    task automatic load_syndromes(input logic [U-1:0][X-1:0] meas);
        stage = STAGE_MEASUREMENT_LOADING;
        for (int k = 0; k < U; k++) begin
            measurements = meas[k];  // First vector ends up in round 0
            next_cycle();
        end
        stage        = STAGE_IDLE;
        measurements = '0;
    endtask

    // One grow cycle, then merge until no unit changed
    task automatic run_iteration();
        stage = STAGE_GROW;
        next_cycle();
        stage = STAGE_MERGE;
        do next_cycle(); while (busy_o != '0);
        stage = STAGE_IDLE;
    endtask

    initial begin
        row_t                row;
        logic [U-1:0][X-1:0] meas;
        logic [31:0]         rng_state;
        int                  assert_failures;
        rng_state    = 32'h2bd8_6bff;
        rst_n        = 1'b0;
        stage        = STAGE_IDLE;
        measurements = '0;
        repeat (10) next_cycle();
        rst_n = 1'b1;
        load_model('0);  // Reset state matches an empty load
        check_against_model();
        for (int r = 0; r < ROWS; r++) begin
            row  = SCENARIOS[r];
            meas = row.meas;
            if (row.random_syndrome) begin
                for (int k = 0; k < U; k++) begin
                    rng_state = xorshift32(rng_state);
                    meas[k]   = rng_state[X-1:0];
                end
            end
            load_syndromes(meas);
            load_model(meas);
            check_against_model();
            for (int it = 0; it < row.iters; it++) begin
                run_iteration();
                grow_model();
                settle_model();
                check_against_model();
            end
            if (!row.random_syndrome) begin
                check_value($sformatf("active_o row %0d", r), 64'(row.exp_active), 64'(active_o));
                check_value($sformatf("correction_o row %0d", r), 64'(row.exp_correction),
                            64'(correction_o));
            end
        end
        assert_failures = dut0.stage_checks.assert_failures;
        $display("Errors: %0d check failures, %0d assertion failures", errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
src/decoder_pkg.sv
src/unit_link_if.sv
src/growth_link.sv
src/processing_unit.sv
src/decoding_graph.sv
test/decoding_graph_checker.sv
test/decoding_graph_tb.sv
